/* vlog.f */
+incdir+.
router_pkg.sv
input_queue.sv
switch_allocator.sv
crossbar.sv
router_top.sv
router_assertions.sv
tb_router.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_router
FILELIST  ?= vlog.f
SIM_ARGS  ?= +verilator+error+limit+1000
OBJ_DIR   ?= obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# pass only if the run printed the pass line
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_router.sv */
`timescale 1ns/10ps

`include "router_params.svh"

module tb_router;

    import router_pkg::*;

    localparam int n = `ROUTER_NUM_PORTS;

    ////////////////////
    // run length

    localparam int reset_cycles = 16;
    // isolated flits get one drain window each
    localparam int lat_flits    = 8;
    localparam int lat_window   = 10;
    // depth flits per input never fill a queue
    localparam int fair_len     = `ROUTER_QUEUE_DEPTH;
    // twice the depth forces overflow
    localparam int burst_len    = 2 * `ROUTER_QUEUE_DEPTH;
    localparam int rand_cycles  = 200;
    localparam int drain_window = 24;
    localparam int stim_cycles  = reset_cycles + lat_flits * lat_window
                                + 2 * fair_len + burst_len + rand_cycles
                                + 4 * drain_window;
    localparam int cycle_limit  = stim_cycles + 64;

    localparam logic [n-1:0] first_port = 1;

    ////////////////////
    // DUT signals

    logic         clk;
    logic         rst_n;
    logic [n-1:0] in_valid;
    flit_t        in_flit [n];
    logic [n-1:0] in_drop;
    logic [n-1:0] out_valid;
    flit_t        out_flit [n];

    // scoreboard with one queue per input-output pair
    flit_t        exp_q [n*n][$];
    // strobes waiting one cycle for their drop flag
    logic [n-1:0] pend_v = '0;
    flit_t        pend_f [n];

    int           sb_errors    = 0;
    int           phase_errors = 0;
    int           drops_seen   = 0;
    int           cycle        = 0;
    integer       seed         = 32'h78c6;
    logic [5:0]   seq_cnt [n]  = '{default: '0};
    string        test_name    = "reset";

    router_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_flit   (in_flit),
        .in_drop   (in_drop),
        .out_valid (out_valid),
        .out_flit  (out_flit)
    );

    // internal stage signals come from router_top scope
    bind router_top router_assertions u_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_flit    (in_flit),
        .in_drop    (in_drop),
        .out_valid  (out_valid),
        .out_flit   (out_flit),
        .head_valid (head_valid),
        .head_flit  (head_flit),
        .sel        (sel)
    );

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // helpers

    // flits not yet delivered or settled
    function automatic int outstanding();
        int total;
        total = $countones(pend_v);
        for (int i = 0; i < n * n; i++)
            total = total + exp_q[i].size();
        return total;
    endfunction

    // src tags the port and seq counts per input
    task automatic put_flit(input int port, input logic dest);
        flit_t  f;
        integer rnd;
        rnd       = $random(seed);
        f.dest    = dest;
        f.src     = port[0];
        f.seq     = seq_cnt[port];
        f.payload = rnd[`ROUTER_FLIT_W-9:0];
        seq_cnt[port] = seq_cnt[port] + 1'b1;
        in_flit[port] <= f;
    endtask

    // one cycle of strobes
    task automatic drive_cycle(input logic [n-1:0] mask, input logic [n-1:0] dests);
        @(posedge clk);
        in_valid <= mask;
        for (int p = 0; p < n; p++)
        begin
            if (mask[p])
                put_flit(p, dests[p]);
        end
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        in_valid <= '0;
    endtask

    // scoreboard has settled by the falling edge
    task automatic wait_drain();
        do
            @(negedge clk);
        while (outstanding() != 0);
    endtask

    task automatic finish_run(input bit timed_out);
        int total;
        total = sb_errors + phase_errors + dut0.u_asserts.fail_count;
        $display("errors: %0d scoreboard, %0d phase, %0d assertion, timeout %0d",
                 sb_errors, phase_errors, dut0.u_asserts.fail_count, timed_out);
        if (total == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    ////////////////////
    // scoreboard

    always @(posedge clk)
    begin : monitor
        flit_t exp_f;
        int    idx;
        if (!rst_n)
            pend_v = '0;
        else
        begin
            // drop flag now belongs to last cycle's strobe
            for (int p = 0; p < n; p++)
            begin
                if (pend_v[p] && in_drop[p])
                    drops_seen = drops_seen + 1;
                else if (pend_v[p])
                    exp_q[p * n + int'(pend_f[p].dest)].push_back(pend_f[p]);
                else if (in_drop[p])
                begin
                    $display("%s: in_drop on input %0d with no strobe the cycle before",
                             test_name, p);
                    sb_errors = sb_errors + 1;
                end
            end
            // deliveries in order per pair
            for (int o = 0; o < n; o++)
            begin
                if (out_valid[o])
                begin
                    idx = int'(out_flit[o].src) * n + o;
                    if (exp_q[idx].size() == 0)
                    begin
                        $display("%s: flit %h on output %0d was never sent or was dropped",
                                 test_name, out_flit[o], o);
                        sb_errors = sb_errors + 1;
                    end
                    else
                    begin
                        exp_f = exp_q[idx].pop_front();
                        if (out_flit[o] !== exp_f)
                        begin
                            $display("[FAIL] %s: output %0d expected %h actual %h",
                                     test_name, o, exp_f, out_flit[o]);
                            sb_errors = sb_errors + 1;
                        end
                    end
                end
            end
            // strobes captured on this edge
            pend_v = in_valid;
            for (int p = 0; p < n; p++)
                pend_f[p] = in_flit[p];
        end
    end

    // hard stop
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle >= cycle_limit)
        begin
            $display("timeout after %0d cycles in %s, %0d flits never arrived",
                     cycle, test_name, outstanding());
            finish_run(1'b1);
        end
    end

    ////////////////////
    // stimulus

    initial
    begin
        integer       rnd;
        logic [n-1:0] mask;
        logic [n-1:0] dests;
        int           drops_before;
        rst_n    = 1'b0;
        in_valid = '0;
        for (int p = 0; p < n; p++)
            in_flit[p] = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // single flits into empty queues on alternating inputs
        test_name = "latency";
        for (int k = 0; k < lat_flits; k++)
        begin
            rnd   = $random(seed);
            mask  = first_port << (k % n);
            dests = rnd[n-1:0];
            drive_cycle(mask, dests);
            idle_inputs();
            wait_drain();
            repeat (2) @(posedge clk);
        end

        // both inputs onto one output and then the other
        test_name    = "fairness";
        drops_before = drops_seen;
        for (int o = 0; o < n; o++)
        begin
            dests = (o == 0) ? '0 : '1;
            repeat (fair_len) drive_cycle('1, dests);
            idle_inputs();
            wait_drain();
        end
        if (drops_seen != drops_before)
        begin
            $display("fairness: in_drop pulsed although no queue was full");
            phase_errors = phase_errors + 1;
        end

        // both inputs overrun their queues on output 0
        test_name    = "overflow";
        drops_before = drops_seen;
        repeat (burst_len) drive_cycle('1, '0);
        idle_inputs();
        wait_drain();
        if (drops_seen == drops_before)
        begin
            $display("overflow: no in_drop pulse seen during the burst");
            phase_errors = phase_errors + 1;
        end

        // random strobes and destinations
        test_name = "random";
        repeat (rand_cycles)
        begin
            rnd   = $random(seed);
            mask  = rnd[n-1:0];
            dests = rnd[n +: n];
            drive_cycle(mask, dests);
        end
        idle_inputs();
        wait_drain();

        repeat (4) @(posedge clk);
        finish_run(1'b0);
    end

endmodule

/* router_assertions.sv */
`timescale 1ns/10ps

`include "router_params.svh"

module router_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic [`ROUTER_NUM_PORTS-1:0] in_valid,
    input router_pkg::flit_t            in_flit [`ROUTER_NUM_PORTS],
    input logic [`ROUTER_NUM_PORTS-1:0] in_drop,
    input logic [`ROUTER_NUM_PORTS-1:0] out_valid,
    input router_pkg::flit_t            out_flit [`ROUTER_NUM_PORTS],
    input logic [`ROUTER_NUM_PORTS-1:0] head_valid,
    input router_pkg::flit_t            head_flit [`ROUTER_NUM_PORTS],
    input router_pkg::port_sel_t        sel [`ROUTER_NUM_PORTS]
);

    import router_pkg::*;

    localparam int n = `ROUTER_NUM_PORTS;

    // failing checks so far
    int fail_count = 0;

    // every head wants output o
    logic [n-1:0] all_req;

    always_comb
    begin
        for (int o = 0; o < n; o++)
        begin
            all_req[o] = 1'b1;
            for (int i = 0; i < n; i++)
                all_req[o] = all_req[o] && head_valid[i] && (int'(head_flit[i].dest) == o);
        end
    end

    ////////////////////
    // reset state

    // covers the first cycle after release too
    a_reset: assert property (@(posedge clk)
        !rst_n |=> (out_valid == '0 && in_drop == '0))
        else
        begin
            fail_count = fail_count + 1;
            $error("out_valid or in_drop high during or right after reset");
        end

    ////////////////////
    // per port checks

    for (genvar p = 0; p < n; p++)
    begin : g_port
        localparam port_sel_t only_p = port_sel_t'(1 << p);

        // delivered flit is on its own dest output
        a_route: assert property (@(posedge clk) disable iff (!rst_n)
            out_valid[p] |-> (int'(out_flit[p].dest) == p))
            else
            begin
                fail_count = fail_count + 1;
                $error("output %0d delivered a flit for another port", p);
            end

        // lone strobe into empty queues, two cycles to the output
        a_latency: assert property (@(posedge clk) disable iff (!rst_n)
            (in_valid == only_p && head_valid == '0)
            |-> ##2 (out_valid[$past(in_flit[p].dest, 2)]
                     && out_flit[$past(in_flit[p].dest, 2)] == $past(in_flit[p], 2)))
            else
            begin
                fail_count = fail_count + 1;
                $error("uncontended flit from input %0d missed its two cycle slot", p);
            end

        // output p as arbiter, winner changes while all inputs compete
        a_fair: assert property (@(posedge clk) disable iff (!rst_n)
            (sel[p] != '0) |=> (!all_req[p] || sel[p] != $past(sel[p])))
            else
            begin
                fail_count = fail_count + 1;
                $error("output %0d granted the same input twice under contention", p);
            end
    end

endmodule

/* router_top.sv */
`timescale 1ns/10ps

`include "router_params.svh"

module router_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`ROUTER_NUM_PORTS-1:0] in_valid,
    input  router_pkg::flit_t            in_flit [`ROUTER_NUM_PORTS],
    output logic [`ROUTER_NUM_PORTS-1:0] in_drop,
    output logic [`ROUTER_NUM_PORTS-1:0] out_valid,
    output router_pkg::flit_t            out_flit [`ROUTER_NUM_PORTS]
);

    import router_pkg::*;

    localparam int n = `ROUTER_NUM_PORTS;

    ////////////////////
    // stage wires

    // queue heads into allocator and crossbar
    logic [n-1:0] head_valid;
    flit_t        head_flit [n];

    // allocator back to the queues
    logic [n-1:0] grant;

    // allocator to crossbar, one select per output
    port_sel_t    sel [n];

    ////////////////////
    // input queues

    // one queue per input port
    for (genvar p = 0; p < n; p++)
    begin : g_queue
        input_queue u_queue (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_valid   (in_valid[p]),
            .in_flit    (in_flit[p]),
            .grant      (grant[p]),
            .head_valid (head_valid[p]),
            .head_flit  (head_flit[p]),
            .drop       (in_drop[p])
        );
    end

    ////////////////////
    // allocation

    // combinational from heads to sel and grant
    switch_allocator u_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_flit  (head_flit),
        .sel        (sel),
        .grant      (grant)
    );

    ////////////////////
    // output stage

    // heads feed the crossbar directly
    // the granted head is registered on the same edge it pops
    crossbar u_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (head_flit),
        .sel       (sel),
        .out_valid (out_valid),
        .out_flit  (out_flit)
    );

endmodule

/* crossbar.sv */
`timescale 1ns/10ps

`include "router_params.svh"

module crossbar (
    input  logic                         clk,
    input  logic                         rst_n,
    input  router_pkg::flit_t            in_flit [`ROUTER_NUM_PORTS],
    input  router_pkg::port_sel_t        sel [`ROUTER_NUM_PORTS],
    output logic [`ROUTER_NUM_PORTS-1:0] out_valid,
    output router_pkg::flit_t            out_flit [`ROUTER_NUM_PORTS]
);

    import router_pkg::*;

    localparam int n = `ROUTER_NUM_PORTS;

    ////////////////////
    // select decode

    // one-hot select matched an input
    logic [n-1:0] hit;
    // flit picked for each output
    flit_t        pick [n];

    always_comb
    begin
        for (int o = 0; o < n; o++)
        begin
            hit[o]  = 1'b0;
            pick[o] = '0;
            // exact one-hot match only
            // zero or multi-hot selects leave hit low
            for (int i = 0; i < n; i++)
            begin
                if (sel[o] == port_sel_t'(1 << i))
                begin
                    hit[o]  = 1'b1;
                    pick[o] = in_flit[i];
                end
            end
        end
    end

    ////////////////////
    // output registers

    // valid for one cycle per delivered flit
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= '0;
        else
            out_valid <= hit;
    end

    // data holds until the next delivery on that output
    always_ff @(posedge clk)
    begin
        for (int o = 0; o < n; o++)
        begin
            if (hit[o])
                out_flit[o] <= pick[o];
        end
    end

endmodule

/* switch_allocator.sv */
`timescale 1ns/10ps

`include "router_params.svh"

module switch_allocator (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`ROUTER_NUM_PORTS-1:0] head_valid,
    input  router_pkg::flit_t            head_flit [`ROUTER_NUM_PORTS],
    output router_pkg::port_sel_t        sel [`ROUTER_NUM_PORTS],
    output logic [`ROUTER_NUM_PORTS-1:0] grant
);

    import router_pkg::*;

    localparam int n     = `ROUTER_NUM_PORTS;
    localparam int ptr_w = (n > 1) ? $clog2(n) : 1;

    ////////////////////
    // request matrix

    // req[o][i] set when input i wants output o
    port_sel_t req [n];

    always_comb
    begin
        for (int o = 0; o < n; o++)
        begin
            for (int i = 0; i < n; i++)
            begin
                // each head names exactly one output
                req[o][i] = head_valid[i] && (int'(head_flit[i].dest) == o);
            end
        end
    end

    ////////////////////
    // round-robin arbiters

    // input with top priority, per output
    logic [ptr_w-1:0] rr_ptr [n];
    // winner index per output
    logic [ptr_w-1:0] win_idx [n];
    // output found a winner this cycle
    logic [n-1:0]     win_any;

    always_comb
    begin
        int idx;
        for (int o = 0; o < n; o++)
        begin
            sel[o]     = '0;
            win_idx[o] = '0;
            win_any[o] = 1'b0;
            // scan once around, starting at the pointer
            for (int k = 0; k < n; k++)
            begin
                idx = (int'(rr_ptr[o]) + k) % n;
                // first requester met wins
                if (!win_any[o] && req[o][idx])
                begin
                    sel[o][idx] = 1'b1;
                    win_idx[o]  = ptr_w'(idx);
                    win_any[o]  = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // grants back to queues

    // one request per input, so at most one sel bit per column
    always_comb
    begin
        grant = '0;
        for (int o = 0; o < n; o++)
            grant = grant | sel[o];
    end

    ////////////////////
    // pointer update

    // pointer moves one past the winner
    // idle outputs keep their pointer
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int o = 0; o < n; o++)
                rr_ptr[o] <= '0;
        end
        else
        begin
            for (int o = 0; o < n; o++)
            begin
                if (win_any[o])
                begin
                    // wrap back to input 0 after the last input
                    if (int'(win_idx[o]) == n - 1)
                        rr_ptr[o] <= '0;
                    else
                        rr_ptr[o] <= win_idx[o] + 1'b1;
                end
            end
        end
    end

endmodule

/* input_queue.sv */
`timescale 1ns/10ps

`include "router_params.svh"

module input_queue #(
    parameter int depth = `ROUTER_QUEUE_DEPTH
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  router_pkg::flit_t in_flit,
    input  logic              grant,
    output logic              head_valid,
    output router_pkg::flit_t head_flit,
    output logic              drop
);

    import router_pkg::*;

    // at least one pointer bit so a depth of 1 still builds
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    // count has to reach depth itself
    localparam int cnt_w = $clog2(depth + 1);

    ////////////////////
    // storage and state

    flit_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    logic full;
    logic push;
    logic pop;

    // wrap at depth-1
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    ////////////////////
    // flags

    assign full = (count == cnt_w'(depth));

    // grant only counts when there is a head to take
    assign pop = grant && head_valid;

    // a pop frees its slot in the same edge
    // so a full queue still takes the new flit
    assign push = in_valid && (!full || pop);

    // oldest entry, visible right after the write edge
    assign head_valid = (count != '0);
    assign head_flit  = mem[rd_ptr];

    ////////////////////
    // pointers and count

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drop   <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // strobe seen but no room, flit is lost
            drop <= in_valid && !push;
        end
    end

    // flit storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_flit;
    end

endmodule

/* router_pkg.sv */
`include "router_params.svh"

package router_pkg;

    ////////////////////
    // flit layout

    // single-flit packet
    // dest sits in the top bit
    typedef struct packed {
        // output port number
        logic                      dest;
        // sending input port
        logic                      src;
        // per-input sequence tag
        logic [5:0]                seq;
        // whatever is left of the flit
        logic [`ROUTER_FLIT_W-9:0] payload;
    } flit_t;

    ////////////////////
    // crossbar select

    // one bit per input, one-hot
    // all zero means nothing this cycle
    typedef logic [`ROUTER_NUM_PORTS-1:0] port_sel_t;

endpackage

/* router_params.svh */
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

////////////////////
// router sizing

// bits per flit
`define ROUTER_FLIT_W 16

// input and output ports
`define ROUTER_NUM_PORTS 2

// entries per input queue
// keep this a power of two
`define ROUTER_QUEUE_DEPTH 4

`endif
